//--- run_sim.sh
#!/bin/sh
# Build and run the HyperBus testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_hbus_top -Mdir obj_dir -o sim_hbus \
    && ./obj_dir/sim_hbus | grep "TEST RESULT: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- src.f
+incdir+verilog
verilog/hbus_pkg.sv
verilog/hbus_cmd_builder.sv
verilog/hbus_read_capture.sv
verilog/hbus_sequencer.sv
verilog/hbus_top.sv
tb/hbus_ram_model.sv
tb/tb_hbus_top.sv

//--- tb/hbus_ram_model.sv
`timescale 1ns/100ps
`default_nettype none

`include "hbus_params.svh"

module hbus_ram_model (
    input  wire                         clk,
    input  wire hbus_pkg::hb_pins_out_t pins_i,
    input  wire                         lat2x_i,
    input  wire                         silent_i,
    output hbus_pkg::hb_pins_in_t       pins_o,
    output hbus_pkg::hb_ca_t            ca_o,
    output logic [1:0]                  beat_cnt_o,
    output int                          txn_cnt_o
);

    logic [15:0] mem [64];
    logic [15:0] regs [4];
    logic [5:0]  idx;
    logic [4:0]  lat_cnt;
    logic [4:0]  lat_len;
    logic [1:0]  gap_run;
    logic        csn_d;
    logic        gap;
    integer      seed;

    initial begin
        seed = 47933;
        // Fill pattern uses all six index bits twice
        for (int i = 0; i < 64; i++) begin
            mem[i] = {2'b10, 6'(i), 2'b01, ~6'(i)};
        end
        regs[0] = 16'h0c81;
        regs[1] = 16'h0001;
        regs[2] = 16'h8f1f;
        regs[3] = 16'hffc1;
        pins_o = '0;
        ca_o = '0;
        beat_cnt_o = '0;
        txn_cnt_o = 0;
        lat_cnt = '0;
        lat_len = '0;
        gap_run = '0;
        idx = '0;
        csn_d = 1'b1;
    end

    always @(posedge clk) begin
        csn_d <= pins_i.csn;
        if (csn_d && !pins_i.csn) begin
            txn_cnt_o <= txn_cnt_o + 1;
        end
        if (pins_i.csn) begin
            beat_cnt_o <= '0;
            lat_cnt <= '0;
            gap_run <= '0;
            pins_o <= '0;
        end else if (beat_cnt_o != 2'd3) begin
            // CA phase, RWDS high asks for doubled latency
            ca_o <= {ca_o[31:0], pins_i.dq_out};
            beat_cnt_o <= beat_cnt_o + 2'd1;
            pins_o.rwds_in <= lat2x_i ? 2'b11 : 2'b00;
            if (beat_cnt_o == 2'd2) begin
                idx <= {ca_o[2:0], pins_i.dq_out[2:0]};
                lat_len <= lat2x_i ? 5'(2 * `HB_TACC_CYCLES) : 5'(`HB_TACC_CYCLES);
            end
        end else begin
            pins_o.rwds_in <= 2'b00;
            if (lat_cnt != 5'd31) begin
                lat_cnt <= lat_cnt + 5'd1;
            end
            if (!ca_o[47] && pins_i.dq_oe && pins_i.rwds_oe) begin
                // RWDS high masks the byte
                if (!pins_i.rwds_out[1]) mem[idx][15:8] <= pins_i.dq_out[15:8];
                if (!pins_i.rwds_out[0]) mem[idx][7:0] <= pins_i.dq_out[7:0];
            end else if (ca_o[47] && !silent_i && lat_cnt >= lat_len - 5'd1) begin
                gap = (($random(seed) & 3) == 0) && (gap_run != 2'd3);
                if (gap) begin
                    gap_run <= gap_run + 2'd1;
                end else begin
                    gap_run <= '0;
                    pins_o.rwds_in <= 2'b10;
                    pins_o.dq_in <= ca_o[46] ? regs[idx[1:0]] : mem[idx];
                    idx <= idx + 6'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_hbus_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "hbus_params.svh"

module tb_hbus_top;

    localparam int TXN_CYCLES = 3 + 2 * `HB_TACC_CYCLES + 8 * 4 + 8;
    localparam int WD_CYCLES = 14 * TXN_CYCLES + 3 * (16 + `HB_RESET_CYCLES + 4)
                               + 3 + 2 * `HB_TACC_CYCLES + `HB_READ_TIMEOUT + 220;

    logic                   clk;
    logic                   rst;
    logic                   cmd_valid;
    hbus_pkg::hb_cmd_t      cmd;
    logic                   busy;
    logic                   done;
    logic                   error;
    logic                   rd_valid;
    hbus_pkg::hb_word_t     rd_data;
    hbus_pkg::hb_pins_out_t pins_out;
    hbus_pkg::hb_pins_in_t  pins_in;
    logic                   lat2x;
    logic                   silent;
    hbus_pkg::hb_ca_t       model_ca;
    logic [1:0]             model_beats;
    int                     model_txns;

    logic [15:0]    shadow [64];
    hbus_pkg::hb_addr_t wr_addr [4];
    integer         seed;
    int             err_cnt;
    int             chk_cnt;
    int             test_cnt;
    int             err_base;
    int             txn_before;
    int             n;

    hbus_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid_i (cmd_valid),
        .cmd_i       (cmd),
        .busy_o      (busy),
        .done_o      (done),
        .error_o     (error),
        .rd_valid_o  (rd_valid),
        .rd_data_o   (rd_data),
        .hbus_pins_o (pins_out),
        .hbus_pins_i (pins_in)
    );

    hbus_ram_model u_model (
        .clk        (clk),
        .pins_i     (pins_out),
        .lat2x_i    (lat2x),
        .silent_i   (silent),
        .pins_o     (pins_in),
        .ca_o       (model_ca),
        .beat_cnt_o (model_beats),
        .txn_cnt_o  (model_txns)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Device stays deselected in reset
    a_rst_idle: assert property (@(posedge clk) !pins_out.rstn |-> pins_out.csn && !pins_out.ck_en)
        else record_failure("csn or ck_en active while the device is in reset");
    // Errors stick and end all traffic
    a_err_sticky: assert property (@(posedge clk) disable iff (rst) error |=> error)
        else record_failure("error_o dropped without a reset");
    a_err_quiet: assert property (@(posedge clk) disable iff (rst) error |-> !done && !rd_valid)
        else record_failure("done_o or rd_valid_o seen while in error");

    task automatic record_failure(input string msg);
        $display("failure at %0t: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic check_value(input string name, input logic [47:0] exp, input logic [47:0] act);
        chk_cnt++;
        assert (exp === act) else begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    function automatic hbus_pkg::hb_ca_t ca_expect(input logic rd, input logic rs,
                                                   input hbus_pkg::hb_addr_t a);
        return {rd, rs, 1'b1, a[31:3], 13'd0, a[2:0]};
    endfunction

    function automatic logic [15:0] reg_value(input logic [1:0] i);
        case (i)
            2'd0: return 16'h0c81;
            2'd1: return 16'h0001;
            2'd2: return 16'h8f1f;
            default: return 16'hffc1;
        endcase
    endfunction

    task automatic finish_test(input string name);
        test_cnt++;
        $display("test %0d %s finished with %0d errors", test_cnt, name, err_cnt - err_base);
        err_base = err_cnt;
    endtask

    task automatic apply_reset();
        int cnt;
        @(negedge clk);
        rst = 1'b1;
        repeat (16) @(negedge clk);
        check_value("error_o", 0, error);
        check_value("busy_o", 1, busy);
        rst = 1'b0;
        cnt = 0;
        while (!pins_out.rstn && cnt < 40) begin
            check_value("csn", 1, pins_out.csn);
            check_value("ck_en", 0, pins_out.ck_en);
            check_value("dq_oe", 0, pins_out.dq_oe);
            check_value("rwds_oe", 0, pins_out.rwds_oe);
            check_value("busy_o", 1, busy);
            cnt++;
            @(negedge clk);
        end
        check_value("rstn low cycles", `HB_RESET_CYCLES, cnt);
        check_value("busy_o", 0, busy);
    endtask

    // Issues a command and checks the three CA beats on cycles 1 to 3
    task automatic send_cmd(input hbus_pkg::hb_cmd_t c, input logic drop);
        hbus_pkg::hb_ca_t exp_ca;
        exp_ca = ca_expect(c.read, c.reg_space, c.addr);
        cmd = c;
        cmd_valid = 1'b1;
        @(negedge clk);
        for (int b = 0; b < 3; b++) begin
            cmd_valid = drop && (b == 1);
            cmd.read = 1'b1;
            check_value("busy_o", 1, busy);
            check_value("csn", 0, pins_out.csn);
            check_value("ck_en", 1, pins_out.ck_en);
            check_value("dq_oe", 1, pins_out.dq_oe);
            check_value("ca beat", exp_ca[47 - 16 * b -: 16], pins_out.dq_out);
            @(negedge clk);
        end
        cmd_valid = 1'b0;
    endtask

    task automatic run_write(input hbus_pkg::hb_addr_t a, input logic [15:0] d,
                             input logic [1:0] m, input logic drop);
        hbus_pkg::hb_cmd_t c;
        logic [15:0] exp_word;
        int cyc;
        c = '0;
        c.addr = a;
        c.wdata = d;
        c.mask = m;
        send_cmd(c, drop);
        cyc = 1;
        while (!pins_out.rwds_oe && cyc < 40) begin
            cyc++;
            @(negedge clk);
        end
        if (cyc >= 40) begin
            record_failure("write data cycle never appeared");
            return;
        end
        check_value("write latency", lat2x ? 2 * `HB_TACC_CYCLES : `HB_TACC_CYCLES, cyc);
        check_value("dq_out", d, pins_out.dq_out);
        check_value("rwds_out", m, pins_out.rwds_out);
        @(negedge clk);
        check_value("done_o", 1, done);
        check_value("csn", 1, pins_out.csn);
        exp_word = shadow[a[5:0]];
        if (!m[1]) exp_word[15:8] = d[15:8];
        if (!m[0]) exp_word[7:0] = d[7:0];
        shadow[a[5:0]] = exp_word;
        check_value("model memory", exp_word, u_model.mem[a[5:0]]);
        check_value("model ca", ca_expect(1'b0, 1'b0, a), model_ca);
        check_value("model beats", 3, model_beats);
        @(negedge clk);
        check_value("done_o", 0, done);
    endtask

    task automatic run_read(input hbus_pkg::hb_addr_t a, input hbus_pkg::hb_len_t len,
                            input logic rs);
        hbus_pkg::hb_cmd_t c;
        logic [15:0] exp_word;
        logic prev;
        logic got_done;
        int k;
        int cyc;
        c = '0;
        c.read = 1'b1;
        c.reg_space = rs;
        c.addr = a;
        c.len = len;
        send_cmd(c, 1'b0);
        k = 0;
        cyc = 0;
        prev = 1'b0;
        got_done = 1'b0;
        while (!got_done && cyc < 200) begin
            if (done) begin
                check_value("rd_valid_o before done_o", 1, prev);
                check_value("rd_valid_o", 0, rd_valid);
                got_done = 1'b1;
            end else if (rd_valid) begin
                exp_word = rs ? reg_value(2'(a[5:0] + 6'(k))) : shadow[a[5:0] + 6'(k)];
                check_value("rd_data_o", exp_word, rd_data);
                k++;
            end
            prev = rd_valid;
            cyc++;
            @(negedge clk);
        end
        if (!got_done) begin
            record_failure("read never signalled done");
        end
        check_value("read word count", len + 1, k);
        check_value("model ca", ca_expect(1'b1, rs, a), model_ca);
    endtask

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("watchdog expired before the tests completed");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        rst = 1'b1;
        cmd_valid = 1'b0;
        cmd = '0;
        lat2x = 1'b0;
        silent = 1'b0;
        seed = 47933;
        err_cnt = 0;
        chk_cnt = 0;
        test_cnt = 0;
        err_base = 0;
        for (int i = 0; i < 64; i++) begin
            shadow[i] = {2'b10, 6'(i), 2'b01, ~6'(i)};
        end

        apply_reset();
        finish_test("reset");

        for (int i = 0; i < 4; i++) begin
            wr_addr[i] = $random(seed);
            run_write(wr_addr[i], 16'($random(seed)), 2'($random(seed)), 1'b0);
        end
        finish_test("write");

        run_read(wr_addr[0], 3'($random(seed)), 1'b0);
        run_read(wr_addr[2], 3'($random(seed)), 1'b0);
        run_read($random(seed), 3'($random(seed)), 1'b0);
        run_read($random(seed), 3'd7, 1'b0);
        finish_test("read burst");

        lat2x = 1'b1;
        run_write(wr_addr[1], 16'($random(seed)), 2'b00, 1'b0);
        run_read(wr_addr[1], 3'($random(seed)), 1'b0);
        lat2x = 1'b0;
        finish_test("2x latency");

        run_read(32'h0000_0001, 3'd2, 1'b1);
        txn_before = model_txns;
        run_write(wr_addr[3], 16'($random(seed)), 2'b01, 1'b1);
        repeat (10) @(negedge clk);
        check_value("transaction count", txn_before + 1, model_txns);
        finish_test("register and drop");

        silent = 1'b1;
        cmd = '0;
        cmd.read = 1'b1;
        cmd_valid = 1'b1;
        @(negedge clk);
        cmd_valid = 1'b0;
        n = 0;
        while (!error && n < 3 + 2 * `HB_TACC_CYCLES + `HB_READ_TIMEOUT + 20) begin
            check_value("done_o", 0, done);
            check_value("rd_valid_o", 0, rd_valid);
            n++;
            @(negedge clk);
        end
        if (!error) begin
            record_failure("error_o never rose on a silent read");
        end
        check_value("csn", 1, pins_out.csn);
        repeat (5) @(negedge clk);
        check_value("error_o", 1, error);
        silent = 1'b0;
        apply_reset();
        check_value("error_o", 0, error);
        finish_test("timeout");

        $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/hbus_cmd_builder.sv
`timescale 1ns/100ps
`default_nettype none

module hbus_cmd_builder (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  load_i,
    input  wire                  shift_i,
    input  wire hbus_pkg::hb_cmd_t cmd_i,
    output hbus_pkg::hb_word_t   ca_beat_o,
    output hbus_pkg::hb_word_t   wdata_o,
    output logic [1:0]           wmask_o
);

    hbus_pkg::hb_ca_t ca_r;
    hbus_pkg::hb_ca_t ca_new;

    // CA word for the incoming command
    always_comb begin
        // Bit 47 is R/W#, high for a read
        ca_new[47] = cmd_i.read;
        // Bit 46 selects register space
        ca_new[46] = cmd_i.reg_space;
        // Linear bursts only
        ca_new[45] = 1'b1;
        // Upper address, then reserved zeros, then the word within the half page
        ca_new[44:16] = cmd_i.addr[31:3];
        ca_new[15:3] = 13'd0;
        ca_new[2:0] = cmd_i.addr[2:0];
    end

    // CA shift register, the top word is the beat on DQ
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ca_r <= '0;
        end else if (load_i) begin
            ca_r <= ca_new;
        end else if (shift_i) begin
            ca_r <= {ca_r[31:0], 16'h0000};
        end
    end

    // Write payload held for the data cycle
    always_ff @(posedge clk) begin
        if (load_i) begin
            wdata_o <= cmd_i.wdata;
            wmask_o <= cmd_i.mask;
        end
    end

    assign ca_beat_o = ca_r[47:32];

endmodule

`default_nettype wire

//--- verilog/hbus_params.svh
`ifndef HBUS_PARAMS_SVH
`define HBUS_PARAMS_SVH

// Address width of the user command
`define HB_ADDR_W 32

// Initial latency in clk cycles at 1x, doubled when the device asks for 2x
`define HB_TACC_CYCLES 5

// Device reset low time after controller reset
`define HB_RESET_CYCLES 8

// Cycles allowed between read strobes before giving up
`define HB_READ_TIMEOUT 32

// Counter widths for the sequencer and the strobe timeout
`define HB_CNT_W 8
`define HB_TOUT_W 6

`endif

//--- verilog/hbus_pkg.sv
`default_nettype none

`include "hbus_params.svh"

package hbus_pkg;

    // Byte-pair address as given by the user
    typedef logic [`HB_ADDR_W-1:0] hb_addr_t;

    // One clk worth of DDR data on the double-width bus
    typedef logic [15:0] hb_word_t;

    // Command/address word, sent as three beats
    typedef logic [47:0] hb_ca_t;

    // Burst length as word count minus one
    typedef logic [2:0] hb_len_t;

    typedef struct packed {
        logic     read;
        logic     reg_space;
        hb_addr_t addr;
        hb_len_t  len;
        hb_word_t wdata;
        logic [1:0] mask;
    } hb_cmd_t;

    typedef struct packed {
        logic       csn;
        logic       rstn;
        logic       ck_en;
        hb_word_t   dq_out;
        logic       dq_oe;
        logic [1:0] rwds_out;
        logic       rwds_oe;
    } hb_pins_out_t;

    typedef struct packed {
        hb_word_t   dq_in;
        logic [1:0] rwds_in;
    } hb_pins_in_t;

    typedef enum logic [2:0] {
        HB_ST_RESET,
        HB_ST_IDLE,
        HB_ST_CMD,
        HB_ST_LATENCY,
        HB_ST_WRITE,
        HB_ST_READ,
        HB_ST_ERROR
    } hb_state_e;

endpackage

`default_nettype wire

//--- verilog/hbus_read_capture.sv
`timescale 1ns/100ps
`default_nettype none

`include "hbus_params.svh"

module hbus_read_capture (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       capture_en_i,
    input  wire hbus_pkg::hb_len_t    len_i,
    input  wire hbus_pkg::hb_pins_in_t pins_i,
    output logic                      word_valid_o,
    output hbus_pkg::hb_word_t        word_o,
    output logic                      last_o,
    output logic                      timeout_o
);

    logic                   strobe;
    hbus_pkg::hb_len_t      word_cnt;
    logic [`HB_TOUT_W-1:0]  tout_cnt;

    // Device marks a valid read word with RWDS 2'b10, anything else is a gap
    assign strobe = capture_en_i && (pins_i.rwds_in == 2'b10);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            word_valid_o <= 1'b0;
            last_o <= 1'b0;
            word_cnt <= '0;
        end else begin
            word_valid_o <= strobe;
            last_o <= strobe && (word_cnt == len_i);
            if (!capture_en_i) begin
                word_cnt <= '0;
            end else if (strobe) begin
                word_cnt <= word_cnt + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (strobe) begin
            word_o <= pins_i.dq_in;
        end
    end

    // Gap counter, saturates at the limit
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tout_cnt <= '0;
        end else if (!capture_en_i || strobe) begin
            tout_cnt <= '0;
        end else if (!timeout_o) begin
            tout_cnt <= tout_cnt + 1'b1;
        end
    end

    assign timeout_o = (tout_cnt == `HB_TOUT_W'(`HB_READ_TIMEOUT));

endmodule

`default_nettype wire

//--- verilog/hbus_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "hbus_params.svh"

module hbus_sequencer (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     cmd_valid_i,
    input  wire hbus_pkg::hb_cmd_t  cmd_i,
    input  wire hbus_pkg::hb_word_t ca_beat_i,
    input  wire hbus_pkg::hb_word_t wdata_i,
    input  wire [1:0]               wmask_i,
    input  wire [1:0]               rwds_in_i,
    input  wire                     word_valid_i,
    input  wire                     last_i,
    input  wire                     timeout_i,
    output logic                    load_o,
    output logic                    shift_o,
    output logic                    capture_en_o,
    output hbus_pkg::hb_len_t       len_o,
    output hbus_pkg::hb_pins_out_t  pins_o,
    output logic                    busy_o,
    output logic                    done_o,
    output logic                    error_o
);

    hbus_pkg::hb_state_e   state;
    logic [`HB_CNT_W-1:0]  cnt;
    logic                  rd_r;
    hbus_pkg::hb_len_t     len_r;
    logic                  done_r;
    logic                  accept;
    logic                  last_word;

    assign accept = cmd_valid_i && (state == hbus_pkg::HB_ST_IDLE);
    assign last_word = word_valid_i && last_i;

    // Builder control
    assign load_o = accept;
    assign shift_o = (state == hbus_pkg::HB_ST_CMD);

    // Capture stops as soon as the last word is seen, so late strobes are ignored
    assign capture_en_o = (state == hbus_pkg::HB_ST_READ) && !last_word;
    assign len_o = len_r;

    assign busy_o = (state != hbus_pkg::HB_ST_IDLE);
    assign done_o = done_r;
    assign error_o = (state == hbus_pkg::HB_ST_ERROR);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= hbus_pkg::HB_ST_RESET;
            cnt <= `HB_CNT_W'(`HB_RESET_CYCLES - 1);
            rd_r <= 1'b0;
            len_r <= '0;
            done_r <= 1'b0;
        end else begin
            done_r <= 1'b0;
            case (state)
                hbus_pkg::HB_ST_RESET: begin
                    if (cnt == '0) begin
                        state <= hbus_pkg::HB_ST_IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end

                hbus_pkg::HB_ST_IDLE: begin
                    if (cmd_valid_i) begin
                        rd_r <= cmd_i.read;
                        len_r <= cmd_i.len;
                        // Three CA beats
                        cnt <= `HB_CNT_W'(2);
                        state <= hbus_pkg::HB_ST_CMD;
                    end
                end

                hbus_pkg::HB_ST_CMD: begin
                    if (cnt == '0) begin
                        // Device asks for doubled latency by holding RWDS high here
                        // Latency counts from the third beat, so the data cycle
                        // lands exactly tACC after it
                        if (rwds_in_i == 2'b11) begin
                            cnt <= `HB_CNT_W'(2 * `HB_TACC_CYCLES - 2);
                        end else begin
                            cnt <= `HB_CNT_W'(`HB_TACC_CYCLES - 2);
                        end
                        state <= hbus_pkg::HB_ST_LATENCY;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end

                hbus_pkg::HB_ST_LATENCY: begin
                    if (cnt == '0) begin
                        if (rd_r) begin
                            state <= hbus_pkg::HB_ST_READ;
                        end else begin
                            state <= hbus_pkg::HB_ST_WRITE;
                        end
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end

                hbus_pkg::HB_ST_WRITE: begin
                    // Single word write, one data cycle
                    done_r <= 1'b1;
                    state <= hbus_pkg::HB_ST_IDLE;
                end

                hbus_pkg::HB_ST_READ: begin
                    if (last_word) begin
                        done_r <= 1'b1;
                        state <= hbus_pkg::HB_ST_IDLE;
                    end else if (timeout_i) begin
                        state <= hbus_pkg::HB_ST_ERROR;
                    end
                end

                hbus_pkg::HB_ST_ERROR: begin
                    // Only rst leaves here
                    state <= hbus_pkg::HB_ST_ERROR;
                end

                default: begin
                    cnt <= `HB_CNT_W'(`HB_RESET_CYCLES - 1);
                    state <= hbus_pkg::HB_ST_RESET;
                end
            endcase
        end
    end

    // Pin drive per state
    always_comb begin
        pins_o.csn = 1'b1;
        pins_o.rstn = 1'b1;
        pins_o.ck_en = 1'b0;
        pins_o.dq_oe = 1'b0;
        pins_o.rwds_out = 2'b00;
        pins_o.rwds_oe = 1'b0;

        // DQ carries write data in the data cycle and the CA beat otherwise
        if (state == hbus_pkg::HB_ST_WRITE) begin
            pins_o.dq_out = wdata_i;
        end else begin
            pins_o.dq_out = ca_beat_i;
        end

        case (state)
            hbus_pkg::HB_ST_RESET: begin
                pins_o.rstn = 1'b0;
            end
            hbus_pkg::HB_ST_CMD: begin
                pins_o.csn = 1'b0;
                pins_o.ck_en = 1'b1;
                pins_o.dq_oe = 1'b1;
            end
            hbus_pkg::HB_ST_LATENCY,
            hbus_pkg::HB_ST_READ: begin
                pins_o.csn = 1'b0;
                pins_o.ck_en = 1'b1;
            end
            hbus_pkg::HB_ST_WRITE: begin
                pins_o.csn = 1'b0;
                pins_o.ck_en = 1'b1;
                pins_o.dq_oe = 1'b1;
                // RWDS high masks the byte
                pins_o.rwds_out = wmask_i;
                pins_o.rwds_oe = 1'b1;
            end
            default: begin
                pins_o.csn = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/hbus_top.sv
`timescale 1ns/100ps
`default_nettype none

module hbus_top (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        cmd_valid_i,
    input  wire hbus_pkg::hb_cmd_t     cmd_i,
    output logic                       busy_o,
    output logic                       done_o,
    output logic                       error_o,
    output logic                       rd_valid_o,
    output hbus_pkg::hb_word_t         rd_data_o,
    output hbus_pkg::hb_pins_out_t     hbus_pins_o,
    input  wire hbus_pkg::hb_pins_in_t hbus_pins_i
);

    // Builder to sequencer
    logic               load;
    logic               shift;
    hbus_pkg::hb_word_t ca_beat;
    hbus_pkg::hb_word_t wdata;
    logic [1:0]         wmask;

    // Capture to sequencer
    logic               capture_en;
    hbus_pkg::hb_len_t  len;
    logic               word_valid;
    hbus_pkg::hb_word_t word;
    logic               last;
    logic               timeout;

    hbus_cmd_builder u_cmd_builder (
        .clk       (clk),
        .rst       (rst),
        .load_i    (load),
        .shift_i   (shift),
        .cmd_i     (cmd_i),
        .ca_beat_o (ca_beat),
        .wdata_o   (wdata),
        .wmask_o   (wmask)
    );

    hbus_read_capture u_read_capture (
        .clk          (clk),
        .rst          (rst),
        .capture_en_i (capture_en),
        .len_i        (len),
        .pins_i       (hbus_pins_i),
        .word_valid_o (word_valid),
        .word_o       (word),
        .last_o       (last),
        .timeout_o    (timeout)
    );

    hbus_sequencer u_sequencer (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_i        (cmd_i),
        .ca_beat_i    (ca_beat),
        .wdata_i      (wdata),
        .wmask_i      (wmask),
        .rwds_in_i    (hbus_pins_i.rwds_in),
        .word_valid_i (word_valid),
        .last_i       (last),
        .timeout_i    (timeout),
        .load_o       (load),
        .shift_o      (shift),
        .capture_en_o (capture_en),
        .len_o        (len),
        .pins_o       (hbus_pins_o),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .error_o      (error_o)
    );

    // Captured words go straight to the user
    assign rd_valid_o = word_valid;
    assign rd_data_o = word;

endmodule

`default_nettype wire
